// ==== mipsCore.f ====
src/mipsTypes.sv
src/memBusTypes.sv
src/registerFile.sv
src/registerDatapath.sv
src/alu.sv
src/controlUnit.sv
src/loadStoreUnit.sv
src/memArbiter.sv
src/mipsCore.sv
sim/mipsCore_assert.sv
sim/mipsCore_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	--top-module mipsCore_tb -f mipsCore.f
./obj_dir/VmipsCore_tb | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// ==== sim/mipsCore_assert.sv ====
module mipsCore_assert (
	input logic clock,
	input logic rstN,
	input logic memReq,
	input memBusTypes::busReq memBus,
	input logic memAck,
	input logic halted
);
	timeunit 1ns;
	timeprecision 1ps;

	busStable: assert property (@(posedge clock) disable iff (!rstN)
		memReq && $past(memReq) |-> $stable(memBus))
		else $error("memBus changed while memReq was high");

	ackNeedsReq: assert property (@(posedge clock) disable iff (!rstN)
		$rose(memAck) |-> memReq)
		else $error("memAck rose without memReq");

	// Req may only drop once the slave has answered.
	reqHeldForAck: assert property (@(posedge clock) disable iff (!rstN)
		$fell(memReq) |-> $past(memAck))
		else $error("memReq fell before memAck rose");

	quietAfterHalt: assert property (@(posedge clock) disable iff (!rstN)
		$past(halted) |-> !$rose(memReq))
		else $error("memReq rose after halted");
endmodule

bind mipsCore mipsCore_assert busChecks (
	.clock(clock),
	.rstN(rstN),
	.memReq(memReq),
	.memBus(memBus),
	.memAck(memAck),
	.halted(halted)
);

// ==== sim/mipsCore_tb.sv ====
module mipsCore_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import memBusTypes::*;

	localparam logic [31:0] ResetPc = 32'h0000_0000;
	localparam int PhaseTimeout = 200;
	localparam int HaltTimeout = 5000;
	localparam int StoreBase = 256; // Store count, then address/data pairs.

	logic clock;
	logic rstN;
	logic memReq;
	busReq memBus;
	logic memAck;
	busResp memResp;
	logic halted;

	logic [31:0] fileData [512];
	logic [31:0] mem [1024];
	logic [7:0] lfsr;
	int cycleCount = 0;
	int storeCount;
	int expectedStores;
	int errors;
	int timeouts;
	bit aborted;

	mipsCore #(.resetPc(ResetPc)) DUT (
		.clock(clock),
		.rstN(rstN),
		.memReq(memReq),
		.memBus(memBus),
		.memAck(memAck),
		.memResp(memResp),
		.halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) cycleCount <= cycleCount + 1;

	// Galois form, taps 8 6 5 4.
	function automatic logic [7:0] stepLfsr(input logic [7:0] state);
		return state[0] ? (state >> 1) ^ 8'hb8 : state >> 1;
	endfunction

	task automatic drawDelay(output int cycles);
		cycles = 0;
		for (int i = 0; i < 3; i++) begin
			cycles = cycles * 2 + int'(lfsr[0]);
			lfsr = stepLfsr(lfsr);
		end
	endtask

	// A wait for a rising req also ends on halted.
	task automatic awaitReq(input logic level, output bit ok);
		int waited;
		waited = 0;
		while (memReq !== level && !(level && halted) && waited < PhaseTimeout) begin
			@(negedge clock);
			waited++;
		end
		ok = memReq === level || (level && halted);
	endtask

	task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
		string name;
		logic [31:0] expAddr;
		logic [31:0] expData;
		name = $sformatf("store%0d", storeCount);
		if (storeCount >= expectedStores) begin
			$display("ERROR: unexpected store of %h to address %h", data, addr);
			errors++;
		end else begin
			expAddr = fileData[StoreBase + 1 + 2 * storeCount];
			expData = fileData[StoreBase + 2 + 2 * storeCount];
			if (addr !== expAddr) begin
				$display("MISMATCH %s address: expected %h, actual %h", name, expAddr, addr);
				errors++;
			end
			if (data !== expData) begin
				$display("MISMATCH %s data: expected %h, actual %h", name, expData, data);
				errors++;
			end
		end
		storeCount++;
	endtask

	// One four-phase cycle as the slave.
	task automatic serveRequest();
		int delay;
		bit ok;
		logic [9:0] index;
		awaitReq(1'b1, ok);
		if (!ok) begin
			$display("ERROR: no memory request within %0d cycles", PhaseTimeout);
			timeouts++;
			aborted = 1'b1;
		end else if (memReq) begin
			drawDelay(delay);
			repeat (delay) @(negedge clock);
			index = memBus.addr[11:2];
			if (memBus.addr[31:12] != '0 || memBus.addr[1:0] != '0) begin
				$display("ERROR: access to %h is outside the memory model", memBus.addr);
				errors++;
			end
			if (memBus.write) begin
				checkStore(memBus.addr, memBus.wdata);
				mem[index] = memBus.wdata;
			end
			memResp.rdata = memBus.write ? '0 : mem[index];
			memAck = 1'b1;
			awaitReq(1'b0, ok);
			if (!ok) begin
				$display("ERROR: memReq still high %0d cycles after ack", PhaseTimeout);
				timeouts++;
				aborted = 1'b1;
			end
			memAck = 1'b0;
			memResp = '0;
		end
	endtask

	initial begin
		rstN = 1'b0;
		memAck = 1'b0;
		memResp = '0;
		lfsr = 8'd53;
		storeCount = 0;
		errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = 32'hdead_0000 | 32'(i << 2); // Unique per address.
		end
		// Words the file leaves out keep the fill.
		for (int i = 0; i < StoreBase; i++) begin
			fileData[i] = mem[i];
		end
		$readmemh("sim/mipsCore_testdata.txt", fileData);
		for (int i = 0; i < StoreBase; i++) begin
			mem[i] = fileData[i];
		end
		expectedStores = fileData[StoreBase];
		repeat (5) @(negedge clock);
		rstN = 1'b1;

		while (!halted && !aborted && cycleCount < HaltTimeout) begin
			serveRequest();
		end
		if (!halted && !aborted) begin
			$display("ERROR: halted not raised within %0d cycles", HaltTimeout);
			timeouts++;
		end
		if (storeCount != expectedStores) begin
			$display("ERROR: %0d stores seen at halt, %0d expected", storeCount, expectedStores);
			errors++;
		end

		// Bus should stay idle after the halt.
		repeat (20) @(negedge clock);
		if (halted && memReq) begin
			$display("ERROR: memory request issued after halt");
			errors++;
		end

		$display("Summary: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end
endmodule

// ==== sim/mipsCore_testdata.txt ====
// Program words from address 0, five per line.
// At @100 the expected store count, then one store per line as address and data.
24010007 2402fffd 00221821 ac030200 00222023 // Constants, addu, subu.
ac040204 00222824 ac050208 00223025 ac06020c // And, or.
0041382a ac070210 24280100 ac080214 8c090214 // Slt, addiu, reload.
25290001 ac090218 10210001 ac06021c 10220001 // Taken beq skips a marker.
ac010220 0c000017 ac060224 ac1f0228 24000055 // Jal over a marker.
ac00022c 0000000d                            // Store r0, break.
@100
0000000a
00000200 00000004
00000204 0000000a
00000208 00000005
0000020c ffffffff
00000210 00000001
00000214 00000107
00000218 00000108 // Loaded word plus one.
00000220 00000007 // Untaken beq path.
00000228 00000058 // Link register.
0000022c 00000000

// ==== src/alu.sv ====
module alu (
	input mipsTypes::aluOp op,
	input mipsTypes::word a,
	input mipsTypes::word b,
	output mipsTypes::word result,
	output logic zero
);
	import mipsTypes::*;

	always_comb begin
		case (op)
			add: result = a + b;
			sub: result = a - b;
			andOp: result = a & b;
			orOp: result = a | b;
			slt: result = {31'b0, $signed(a) < $signed(b)};
			default: result = '0;
		endcase
	end

	// Equal operands when op is sub.
	assign zero = result == '0;
endmodule

// ==== src/controlUnit.sv ====
module controlUnit #(
	parameter mipsTypes::word resetPc = 32'h0000_0000
) (
	input logic clock,
	input logic rstN,
	output logic fetchReq,
	input logic fetchAck,
	output memBusTypes::busReq fetchBus,
	input memBusTypes::busResp fetchResp,
	output mipsTypes::word instruction,
	output mipsTypes::word pcAddr,
	output mipsTypes::regControl control,
	output mipsTypes::aluOp aluSel,
	output logic immSel,
	output logic memStart,
	output logic memWrite,
	input logic memDone,
	input logic zero,
	output logic halted
);
	import mipsTypes::*;

	typedef enum logic [2:0] {
		stFetch,
		stDecode,
		stExecute,
		stMemory,
		stWriteBack,
		stHalt
	} state;

	state current;
	word pc;
	word ir;
	logic fetchWaitLow; // Response taken, ack not yet low.
	rFormat rInstr;
	iFormat iInstr;
	jFormat jInstr;
	logic writesReg;
	logic isMem;
	word pcPlus4;
	word branchOffset;
	word pcNext;

	assign rInstr = rFormat'(ir);
	assign iInstr = iFormat'(ir);
	assign jInstr = jFormat'(ir);
	assign instruction = ir;
	assign pcAddr = pc;
	assign fetchBus = '{addr: pc, wdata: '0, write: 1'b0};

	assign isMem = rInstr.op == LW || rInstr.op == SW;
	assign memWrite = rInstr.op == SW;
	assign memStart = current == stExecute && isMem; // One cycle per access.

	always_comb begin
		control = '{port1None, port2None, writeNone, dataAlu, 1'b0};
		aluSel = add;
		immSel = 1'b0;
		writesReg = 1'b0;
		case (rInstr.op)
			SPECIAL: begin
				control.port1Addr = port1Rs;
				control.port2Addr = port2Rt;
				control.writeAddr = writeRd;
				writesReg = rInstr.fn inside {ADDU, SUBU, AND, OR, SLT};
				case (rInstr.fn)
					SUBU: aluSel = sub;
					AND: aluSel = andOp;
					OR: aluSel = orOp;
					SLT: aluSel = slt;
					default: aluSel = add;
				endcase
			end
			ADDIU, LW: begin
				control.port1Addr = port1Rs;
				control.writeAddr = writeRt;
				control.writeData = rInstr.op == LW ? dataMemory : dataAlu;
				immSel = 1'b1;
				writesReg = 1'b1;
			end
			SW: begin
				control.port1Addr = port1Rs;
				control.port2Addr = port2Rt; // Store data.
				immSel = 1'b1;
			end
			BEQ: begin
				control.port1Addr = port1Rs;
				control.port2Addr = port2Rt;
				aluSel = sub;
			end
			JAL: begin
				control.writeAddr = writeR31;
				control.writeData = dataPc;
				writesReg = 1'b1;
			end
			default: ;
		endcase
		control.writeEnable = writesReg && current == stWriteBack;
	end

	assign pcPlus4 = pc + 32'd4;
	assign branchOffset = {{14{iInstr.imm[15]}}, iInstr.imm, 2'b00};

	always_comb begin
		case (rInstr.op)
			BEQ: pcNext = zero ? pcPlus4 + branchOffset : pcPlus4;
			JAL: pcNext = {pcPlus4[31:28], jInstr.target, 2'b00};
			default: pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clock) begin
		if (current == stFetch && fetchReq && fetchAck) begin
			ir <= fetchResp.rdata;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			current <= stFetch;
			pc <= resetPc;
			fetchReq <= 1'b0;
			fetchWaitLow <= 1'b0;
			halted <= 1'b0;
		end else begin
			case (current)
				stFetch: begin
					if (!fetchReq && !fetchWaitLow && !fetchAck) begin
						fetchReq <= 1'b1;
					end else if (fetchReq && fetchAck) begin
						fetchReq <= 1'b0;
						fetchWaitLow <= 1'b1;
					end else if (fetchWaitLow && !fetchAck) begin
						fetchWaitLow <= 1'b0;
						current <= stDecode;
					end
				end
				stDecode: begin
					if (rInstr.op == SPECIAL && rInstr.fn == BREAK) begin
						current <= stHalt;
						halted <= 1'b1;
					end else begin
						current <= stExecute;
					end
				end
				stExecute: current <= isMem ? stMemory : stWriteBack;
				stMemory: begin
					if (memDone) begin
						current <= stWriteBack;
					end
				end
				stWriteBack: begin
					pc <= pcNext; // JAL link already written from the old pc.
					current <= stFetch;
				end
				default: current <= stHalt;
			endcase
		end
	end
endmodule

// ==== src/loadStoreUnit.sv ====
module loadStoreUnit (
	input logic clock,
	input logic rstN,
	input logic start,
	input logic write,
	input mipsTypes::word addr,
	input mipsTypes::word storeData,
	output logic done,
	output mipsTypes::word loadData,
	output logic req,
	input logic ack,
	output memBusTypes::busReq bus,
	input memBusTypes::busResp resp
);
	logic waitAckLow;
	logic launch;

	assign launch = start && !req && !waitAckLow && !ack;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			req <= 1'b0;
			waitAckLow <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (launch) begin
				req <= 1'b1;
			end else if (req && ack) begin
				req <= 1'b0;
				waitAckLow <= 1'b1;
			end else if (waitAckLow && !ack) begin
				waitAckLow <= 1'b0;
				done <= 1'b1; // Handshake complete.
			end
		end
	end

	always_ff @(posedge clock) begin
		if (launch) begin
			bus <= '{addr: addr, wdata: storeData, write: write};
		end
		if (req && ack && !bus.write) begin
			loadData <= resp.rdata;
		end
	end
endmodule

// ==== src/memArbiter.sv ====
module memArbiter (
	input logic clock,
	input logic rstN,
	input logic fetchReq,
	input logic lsReq,
	input memBusTypes::busReq fetchBus,
	input memBusTypes::busReq lsBus,
	output logic fetchAck,
	output logic lsAck,
	output memBusTypes::busResp fetchResp,
	output memBusTypes::busResp lsResp,
	output logic memReq,
	output memBusTypes::busReq memBus,
	input logic memAck,
	input memBusTypes::busResp memResp
);
	import memBusTypes::*;

	busMaster grant; // Also the last master served.
	logic busy;
	logic acked;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			grant <= loadStore; // Fetch wins the first tie.
			busy <= 1'b0;
			acked <= 1'b0;
		end else if (!busy) begin
			if (!memAck && (fetchReq || lsReq)) begin
				busy <= 1'b1;
				if (fetchReq && lsReq) begin
					grant <= grant == fetch ? loadStore : fetch;
				end else begin
					grant <= fetchReq ? fetch : loadStore;
				end
			end
		end else if (memAck) begin
			acked <= 1'b1;
		end else if (acked) begin
			busy <= 1'b0; // Released once ack is back low.
			acked <= 1'b0;
		end
	end

	assign memReq = busy && (grant == fetch ? fetchReq : lsReq);
	assign memBus = grant == fetch ? fetchBus : lsBus;

	assign fetchAck = grant == fetch && memAck;
	assign lsAck = grant == loadStore && memAck;
	assign fetchResp = grant == fetch ? memResp : '0;
	assign lsResp = grant == loadStore ? memResp : '0;
endmodule

// ==== src/memBusTypes.sv ====
package memBusTypes;
	// Held stable by the master while req is high.
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic write;
	} busReq;

	// Valid while ack is high.
	typedef struct packed {
		logic [31:0] rdata;
	} busResp;

	typedef enum logic {fetch, loadStore} busMaster;
endpackage

// ==== src/mipsCore.sv ====
module mipsCore #(
	parameter mipsTypes::word resetPc = 32'h0000_0000
) (
	input logic clock,
	input logic rstN,
	output logic memReq,
	output memBusTypes::busReq memBus,
	input logic memAck,
	input memBusTypes::busResp memResp,
	output logic halted
);
	import mipsTypes::*;
	import memBusTypes::*;

	word instruction;
	word pcAddr;
	word port1;
	word port2;
	word immExt;
	word aluB;
	word aluResult;
	word loadData;
	iFormat iInstr;
	regControl control;
	aluOp aluSel;
	logic immSel;
	logic zero;
	logic memStart;
	logic memWrite;
	logic memDone;
	logic fetchReq;
	logic fetchAck;
	logic lsReq;
	logic lsAck;
	busReq fetchBus;
	busReq lsBus;
	busResp fetchResp;
	busResp lsResp;

	assign iInstr = iFormat'(instruction);
	assign immExt = {{16{iInstr.imm[15]}}, iInstr.imm}; // Sign extended.
	assign aluB = immSel ? immExt : port2;

	controlUnit #(.resetPc(resetPc)) control0 (
		.clock(clock),
		.rstN(rstN),
		.fetchReq(fetchReq),
		.fetchAck(fetchAck),
		.fetchBus(fetchBus),
		.fetchResp(fetchResp),
		.instruction(instruction),
		.pcAddr(pcAddr),
		.control(control),
		.aluSel(aluSel),
		.immSel(immSel),
		.memStart(memStart),
		.memWrite(memWrite),
		.memDone(memDone),
		.zero(zero),
		.halted(halted)
	);

	registerDatapath datapath (
		.clock(clock),
		.rstN(rstN),
		.control(control),
		.pcAddr(pcAddr),
		.loadData(loadData),
		.aluResult(aluResult),
		.instruction(instruction),
		.port1(port1),
		.port2(port2)
	);

	alu alu0 (
		.op(aluSel),
		.a(port1),
		.b(aluB),
		.result(aluResult),
		.zero(zero)
	);

	loadStoreUnit lsu (
		.clock(clock),
		.rstN(rstN),
		.start(memStart),
		.write(memWrite),
		.addr(aluResult),
		.storeData(port2),
		.done(memDone),
		.loadData(loadData),
		.req(lsReq),
		.ack(lsAck),
		.bus(lsBus),
		.resp(lsResp)
	);

	memArbiter arbiter (
		.clock(clock),
		.rstN(rstN),
		.fetchReq(fetchReq),
		.lsReq(lsReq),
		.fetchBus(fetchBus),
		.lsBus(lsBus),
		.fetchAck(fetchAck),
		.lsAck(lsAck),
		.fetchResp(fetchResp),
		.lsResp(lsResp),
		.memReq(memReq),
		.memBus(memBus),
		.memAck(memAck),
		.memResp(memResp)
	);
endmodule

// ==== src/mipsTypes.sv ====
package mipsTypes;
	typedef logic [31:0] word;
	typedef logic [4:0] regAddr;
	typedef logic [15:0] immediate;
	typedef logic [25:0] jumpIndex;

	typedef enum logic [5:0] {
		SPECIAL = 6'h00,
		JAL     = 6'h03,
		BEQ     = 6'h04,
		ADDIU   = 6'h09,
		LW      = 6'h23,
		SW      = 6'h2b
	} opcode;

	// Function field of SPECIAL.
	typedef enum logic [5:0] {
		BREAK = 6'h0d,
		ADDU  = 6'h21,
		SUBU  = 6'h23,
		AND   = 6'h24,
		OR    = 6'h25,
		SLT   = 6'h2a
	} funct;

	typedef struct packed {
		opcode op;
		regAddr rs;
		regAddr rt;
		regAddr rd;
		logic [4:0] shamt;
		funct fn;
	} rFormat;

	typedef struct packed {
		opcode op;
		regAddr rs;
		regAddr rt;
		immediate imm;
	} iFormat;

	typedef struct packed {
		opcode op;
		jumpIndex target;
	} jFormat;

	typedef enum logic [2:0] {add, sub, andOp, orOp, slt} aluOp;

	typedef enum logic [1:0] {port1Rs, port1Rt, port1None} port1AddrSource;
	typedef enum logic [1:0] {port2Rs, port2Rt, port2None} port2AddrSource;
	typedef enum logic [1:0] {writeRd, writeRt, writeR31, writeNone} writeAddrSource;
	typedef enum logic [1:0] {dataAlu, dataMemory, dataPc} writeDataSource;

	typedef struct packed {
		port1AddrSource port1Addr;
		port2AddrSource port2Addr;
		writeAddrSource writeAddr;
		writeDataSource writeData;
		logic writeEnable;
	} regControl;
endpackage

// ==== src/registerDatapath.sv ====
module registerDatapath (
	input logic clock,
	input logic rstN,
	input mipsTypes::regControl control,
	input mipsTypes::word pcAddr,
	input mipsTypes::word loadData,
	input mipsTypes::word aluResult,
	input mipsTypes::word instruction,
	output mipsTypes::word port1,
	output mipsTypes::word port2
);
	import mipsTypes::*;

	rFormat fields;
	regAddr rd1Addr;
	regAddr rd2Addr;
	regAddr wrAddr;
	word wrData;

	assign fields = rFormat'(instruction);

	always_comb begin
		case (control.port1Addr)
			port1Rs: rd1Addr = fields.rs;
			port1Rt: rd1Addr = fields.rt;
			default: rd1Addr = '0;
		endcase
	end

	always_comb begin
		case (control.port2Addr)
			port2Rs: rd2Addr = fields.rs;
			port2Rt: rd2Addr = fields.rt;
			default: rd2Addr = '0;
		endcase
	end

	always_comb begin
		case (control.writeAddr)
			writeRd: wrAddr = fields.rd;
			writeRt: wrAddr = fields.rt;
			writeR31: wrAddr = 5'd31; // Link register.
			default: wrAddr = '0;
		endcase
	end

	always_comb begin
		case (control.writeData)
			dataMemory: wrData = loadData;
			dataPc: wrData = pcAddr + 32'd4;
			default: wrData = aluResult;
		endcase
	end

	registerFile regs (
		.clock(clock),
		.rstN(rstN),
		.rd1Addr(rd1Addr),
		.rd2Addr(rd2Addr),
		.wrAddr(wrAddr),
		.rd1Data(port1),
		.rd2Data(port2),
		.wrData(wrData),
		.wrEnable(control.writeEnable)
	);
endmodule

// ==== src/registerFile.sv ====
module registerFile (
	input logic clock,
	input logic rstN,
	input mipsTypes::regAddr rd1Addr,
	input mipsTypes::regAddr rd2Addr,
	input mipsTypes::regAddr wrAddr,
	output mipsTypes::word rd1Data,
	output mipsTypes::word rd2Data,
	input mipsTypes::word wrData,
	input logic wrEnable
);
	import mipsTypes::*;

	word regs [32];

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEnable && wrAddr != '0) begin // r0 stays zero.
			regs[wrAddr] <= wrData;
		end
	end

	// Combinational reads.
	assign rd1Data = regs[rd1Addr];
	assign rd2Data = regs[rd2Addr];
endmodule
